// ==== testbench/nice_testdata.hex ====
// 16 memory words from byte address 0x00, then the error address
// records after that: instruction, rs1, expected rdat, expected err
00000011 00000022 00000033 11111111
80000000 80000001 fffffff0 0000000f
12345678 9abcdef0 0badf00d deadbeef
00001000 00002000 00003000 7fffffff
0000002c
// lbuf from 0x00, then sbuf to 0x20
0200207b 00000000 00000000 00000000
0400207b 00000020 00000000 00000000
// rowsum over 0x10 wraps, then store the accumulated row to 0x30
0c00607b 00000010 fffffff1 00000000
0400207b 00000030 00000000 00000000
// lbuf over the error word at 0x2c
0200207b 00000024 00000000 00000001
// undecoded custom-3, dropped
0000007b 00000000 00000000 00000000
// rowsum with err back low, store to 0x34, last rowsum
0c00607b 00000000 00000066 00000000
0400207b 00000034 00000000 00000000
0c00607b 00000008 91111144 00000000

// ==== project.f ====
hw/nice_pkg.sv
hw/nice_beat_if.sv
hw/nice_decode.sv
hw/nice_sequencer.sv
hw/rowsum_accumulator.sv
hw/row_buffer.sv
hw/nice_core.sv
testbench/nice_core_tb.sv

// ==== Makefile ====
TOP := nice_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "All checks passed" > /dev/null

clean:
	rm -rf obj_dir

// ==== testbench/nice_core_tb.sv ====
// model memory spans byte addresses 0x00 to 0x3c; responses return in order, at least a cycle late
module nice_core_tb;

   // own copies of the custom-3 encodings, rd/rs1/rs2 fields left zero
   localparam logic [31:0] LBUF_INST   = 32'h0200207b;
   localparam logic [31:0] SBUF_INST   = 32'h0400207b;
   localparam logic [31:0] ROWSUM_INST = 32'h0c00607b;

   localparam int MEM_WORDS      = 16;
   localparam int ROW_LEN        = 3;
   localparam int NUM_RECORDS    = 9;
   localparam int DATA_WORDS     = MEM_WORDS + 1 + 4 * NUM_RECORDS;
   localparam int TIMEOUT_CYCLES = 200;

   logic        nice_clk           = 1'b0;
   logic        reset              = 1'b1;
   logic        nice_req_valid     = 1'b0;
   logic [31:0] nice_req_inst      = '0;
   logic [31:0] nice_req_rs1       = '0;
   logic [31:0] nice_req_rs2       = '0;
   logic        nice_rsp_ready     = 1'b0;
   logic        nice_icb_cmd_ready = 1'b0;
   logic        nice_icb_rsp_valid = 1'b0;
   logic [31:0] nice_icb_rsp_rdata = '0;
   logic        nice_icb_rsp_err   = 1'b0;

   logic        nice_mem_holdup;
   logic        nice_req_ready;
   logic        nice_rsp_valid;
   logic [31:0] nice_rsp_rdat;
   logic        nice_rsp_err;
   logic        nice_icb_cmd_valid;
   logic [31:0] nice_icb_cmd_addr;
   logic        nice_icb_cmd_read;
   logic [31:0] nice_icb_cmd_wdata;

   // memory image, error address, then four-word records
   logic [31:0] testdata [DATA_WORDS];
   // model memory as the DUT sees it
   logic [31:0] mem      [MEM_WORDS];
   // expected memory and row contents
   logic [31:0] ref_mem  [MEM_WORDS];
   logic [31:0] ref_row  [ROW_LEN];

   // instruction in flight, set by the driver and read by the memory model
   logic [31:0] cur_rs1   = '0;
   logic        cur_write = 1'b0;
   int unsigned cmd_base  = 0;
   int unsigned cmd_limit = 0;
   // commands taken so far, only the memory model counts
   int unsigned cmd_total = 0;

   always #10 nice_clk = ~nice_clk;

   nice_core dut_i (
      .nice_clk           (nice_clk),
      .reset              (reset),
      .nice_mem_holdup    (nice_mem_holdup),
      .nice_req_valid     (nice_req_valid),
      .nice_req_ready     (nice_req_ready),
      .nice_req_inst      (nice_req_inst),
      .nice_req_rs1       (nice_req_rs1),
      .nice_req_rs2       (nice_req_rs2),
      .nice_rsp_valid     (nice_rsp_valid),
      .nice_rsp_ready     (nice_rsp_ready),
      .nice_rsp_rdat      (nice_rsp_rdat),
      .nice_rsp_err       (nice_rsp_err),
      .nice_icb_cmd_valid (nice_icb_cmd_valid),
      .nice_icb_cmd_ready (nice_icb_cmd_ready),
      .nice_icb_cmd_addr  (nice_icb_cmd_addr),
      .nice_icb_cmd_read  (nice_icb_cmd_read),
      .nice_icb_cmd_wdata (nice_icb_cmd_wdata),
      .nice_icb_rsp_valid (nice_icb_rsp_valid),
      .nice_icb_rsp_rdata (nice_icb_rsp_rdata),
      .nice_icb_rsp_err   (nice_icb_rsp_err)
   );

   // LCG step, each caller keeps its own state
   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // memory model
   ////////////////////////////////////////////////////////////////////////////

   initial begin : memory_model
      int unsigned cycle;
      int unsigned due;
      int unsigned rsp_due [$];
      logic [31:0] rsp_data [$];
      logic        rsp_errq [$];
      logic [31:0] mem_rng;
      logic [31:0] exp_addr;
      int          i;
      cycle   = 0;
      mem_rng = 32'h53bb;
      $readmemh("testbench/nice_testdata.hex", testdata);
      for (i = 0; i < MEM_WORDS; i++) begin
         mem[i] = testdata[i];
      end
      forever begin
         @(negedge nice_clk);
         cycle++;
         // oldest pending response goes out once its delay is up
         if ((rsp_due.size() > 0) && (rsp_due[0] <= cycle)) begin
            nice_icb_rsp_valid = 1'b1;
            nice_icb_rsp_rdata = rsp_data.pop_front();
            nice_icb_rsp_err   = rsp_errq.pop_front();
            void'(rsp_due.pop_front());
         end else begin
            nice_icb_rsp_valid = 1'b0;
            nice_icb_rsp_rdata = '0;
            nice_icb_rsp_err   = 1'b0;
         end
         // ready roughly three cycles in four
         mem_rng = lcg_step(mem_rng);
         nice_icb_cmd_ready = (mem_rng[20:19] != 2'b00);
         #5;
         if (!reset && nice_icb_cmd_valid && nice_icb_cmd_ready) begin
            assert (cmd_total - cmd_base < cmd_limit)
               else report_failure("memory command issued beyond the words of the instruction");
            exp_addr = cur_rs1 + (cmd_total - cmd_base) * 4;
            assert (nice_icb_cmd_addr == exp_addr)
               else report_failure($sformatf("FAILED nice_icb_cmd_addr: got %08h expected %08h",
                                             nice_icb_cmd_addr, exp_addr));
            assert (nice_icb_cmd_read == !cur_write)
               else report_failure($sformatf("FAILED nice_icb_cmd_read: got %h expected %h",
                                             nice_icb_cmd_read, !cur_write));
            cmd_total++;
            if (nice_icb_cmd_read) begin
               rsp_data.push_back(mem[nice_icb_cmd_addr[5:2]]);
            end else begin
               mem[nice_icb_cmd_addr[5:2]] = nice_icb_cmd_wdata;
               rsp_data.push_back('0);
            end
            rsp_errq.push_back(nice_icb_cmd_addr == testdata[MEM_WORDS]);
            // at least one cycle late, never ahead of an older response
            due = cycle + 1 + 32'(mem_rng[25:24]);
            if ((rsp_due.size() > 0) && (due < rsp_due[$])) begin
               due = rsp_due[$];
            end
            rsp_due.push_back(due);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // request and response side
   ////////////////////////////////////////////////////////////////////////////

   logic [31:0] drv_rng = 32'h53bb;

   task automatic send_request(input logic [31:0] inst, input logic [31:0] rs1);
      int   waited;
      logic accepted;
      accepted = 1'b0;
      for (waited = 0; (waited < TIMEOUT_CYCLES) && !accepted; waited++) begin
         @(negedge nice_clk);
         nice_req_valid = 1'b1;
         nice_req_inst  = inst;
         nice_req_rs1   = rs1;
         #5;
         accepted = nice_req_ready;
      end
      assert (accepted) else report_failure("timeout waiting for nice_req_ready");
      @(negedge nice_clk);
      nice_req_valid = 1'b0;
      nice_req_inst  = '0;
   endtask

   // hold ready low for a random time, the response must not move
   task automatic take_response(input logic [31:0] exp_rdat, input logic exp_err);
      int          waited;
      int          hold;
      int          i;
      logic        seen;
      logic [31:0] held_rdat;
      logic        held_err;
      seen = 1'b0;
      for (waited = 0; (waited < TIMEOUT_CYCLES) && !seen; waited++) begin
         @(negedge nice_clk);
         #5;
         seen = nice_rsp_valid;
         assert (nice_mem_holdup)
            else report_failure("FAILED nice_mem_holdup: got 0 expected 1");
      end
      assert (seen) else report_failure("timeout waiting for nice_rsp_valid");
      held_rdat = nice_rsp_rdat;
      held_err  = nice_rsp_err;
      drv_rng   = lcg_step(drv_rng);
      hold      = 32'(drv_rng[23:16]) % 6;
      for (i = 0; i < hold; i++) begin
         @(negedge nice_clk);
         #5;
         assert (nice_rsp_valid)
            else report_failure("FAILED nice_rsp_valid: got 0 expected 1");
         assert (nice_rsp_rdat == held_rdat)
            else report_failure($sformatf("FAILED nice_rsp_rdat: got %08h expected %08h",
                                          nice_rsp_rdat, held_rdat));
         assert (nice_rsp_err == held_err)
            else report_failure($sformatf("FAILED nice_rsp_err: got %h expected %h",
                                          nice_rsp_err, held_err));
      end
      @(negedge nice_clk);
      nice_rsp_ready = 1'b1;
      #5;
      assert (nice_rsp_rdat == exp_rdat)
         else report_failure($sformatf("FAILED nice_rsp_rdat: got %08h expected %08h",
                                       nice_rsp_rdat, exp_rdat));
      assert (nice_rsp_err == exp_err)
         else report_failure($sformatf("FAILED nice_rsp_err: got %h expected %h",
                                       nice_rsp_err, exp_err));
      @(negedge nice_clk);
      nice_rsp_ready = 1'b0;
      #5;
      // handshake cycle returns the FSM to idle
      assert (!nice_rsp_valid && !nice_mem_holdup)
         else report_failure("DUT still busy after the response handshake");
   endtask

   // dropped instruction, nothing may move on either port
   task automatic check_quiet(input int cycles);
      int i;
      for (i = 0; i < cycles; i++) begin
         @(negedge nice_clk);
         #5;
         assert (!nice_icb_cmd_valid)
            else report_failure("FAILED nice_icb_cmd_valid: got 1 expected 0");
         assert (!nice_rsp_valid)
            else report_failure("FAILED nice_rsp_valid: got 1 expected 0");
      end
   endtask

   // reference row and memory after a completed instruction
   task automatic update_reference(input logic [31:0] inst, input logic [31:0] rs1);
      logic [3:0] w;
      int         i;
      for (i = 0; i < ROW_LEN; i++) begin
         w = rs1[5:2] + 4'(i);
         if (inst == LBUF_INST) begin
            ref_row[i] = ref_mem[w];
         end else if (inst == SBUF_INST) begin
            ref_mem[w] = ref_row[i];
         end else begin
            ref_row[i] = ref_row[i] + ref_mem[w];
         end
      end
   endtask

   task automatic compare_memory();
      int i;
      for (i = 0; i < MEM_WORDS; i++) begin
         assert (mem[i] == ref_mem[i])
            else report_failure($sformatf("FAILED mem[%0d]: got %08h expected %08h",
                                          i, mem[i], ref_mem[i]));
      end
   endtask

   task automatic run_record(input int r);
      int          base;
      logic [31:0] inst;
      logic [31:0] rs1;
      base = MEM_WORDS + 1 + 4 * r;
      inst = testdata[base];
      rs1  = testdata[base + 1];
      cmd_base = cmd_total;
      if ((inst == LBUF_INST) || (inst == SBUF_INST) || (inst == ROWSUM_INST)) begin
         cur_rs1   = rs1;
         cur_write = (inst == SBUF_INST);
         cmd_limit = ROW_LEN;
         send_request(inst, rs1);
         take_response(testdata[base + 2], testdata[base + 3][0]);
         assert (cmd_total - cmd_base == ROW_LEN)
            else report_failure("instruction did not issue exactly three memory commands");
         update_reference(inst, rs1);
         compare_memory();
      end else begin
         cmd_limit = 0;
         send_request(inst, rs1);
         check_quiet(8);
      end
   endtask

   initial begin : driver
      int r;
      int i;
      for (i = 0; i < ROW_LEN; i++) begin
         ref_row[i] = '0;
      end
      repeat (10) @(negedge nice_clk);
      reset = 1'b0;
      #5;
      assert (!nice_rsp_valid && !nice_icb_cmd_valid && !nice_mem_holdup)
         else report_failure("outputs not idle after reset");
      for (i = 0; i < MEM_WORDS; i++) begin
         ref_mem[i] = testdata[i];
      end
      for (r = 0; r < NUM_RECORDS; r++) begin
         run_record(r);
      end
      compare_memory();
      $display("All checks passed");
      $finish;
   end

endmodule

// ==== hw/nice_core.sv ====
// one-word accesses only; responses are always taken and must come back in order
module nice_core (
   input  logic            nice_clk,
   input  logic            reset,
   output logic            nice_mem_holdup,
   input  logic            nice_req_valid,
   output logic            nice_req_ready,
   input  nice_pkg::xlen_t nice_req_inst,
   input  nice_pkg::xlen_t nice_req_rs1,
   input  nice_pkg::xlen_t nice_req_rs2,
   output logic            nice_rsp_valid,
   input  logic            nice_rsp_ready,
   output nice_pkg::xlen_t nice_rsp_rdat,
   output logic            nice_rsp_err,
   output logic            nice_icb_cmd_valid,
   input  logic            nice_icb_cmd_ready,
   output nice_pkg::addr_t nice_icb_cmd_addr,
   output logic            nice_icb_cmd_read,
   output nice_pkg::xlen_t nice_icb_cmd_wdata,
   input  logic            nice_icb_rsp_valid,
   input  nice_pkg::xlen_t nice_icb_rsp_rdata,
   input  logic            nice_icb_rsp_err
);
   import nice_pkg::*;

   // nice_req_rs2 stays on the port for the core, no instruction reads it

   nice_op_e op;
   row_idx_t rd_idx;
   xlen_t    rd_data;
   row_idx_t col_idx;
   xlen_t    col_data;
   logic     buf_we;
   row_idx_t buf_idx;
   xlen_t    buf_wdata;
   logic     sum_done;
   xlen_t    row_sum;

   // read beats from sequencer to accumulator
   nice_beat_if beat_bus ();

   ////////////////////////////////////////////////////////////////////////////
   // decode, sequence, accumulate
   ////////////////////////////////////////////////////////////////////////////

   nice_decode u_decode (
      .req_valid (nice_req_valid),
      .req_inst  (nice_req_inst),
      .op        (op)
   );

   // rs1 carries a byte address here
   nice_sequencer u_sequencer (
      .nice_clk      (nice_clk),
      .reset         (reset),
      .op            (op),
      .req_valid     (nice_req_valid),
      .req_rs1       (addr_t'(nice_req_rs1)),
      .req_ready     (nice_req_ready),
      .rsp_valid     (nice_rsp_valid),
      .rsp_ready     (nice_rsp_ready),
      .rsp_rdat      (nice_rsp_rdat),
      .rsp_err       (nice_rsp_err),
      .cmd_valid     (nice_icb_cmd_valid),
      .cmd_ready     (nice_icb_cmd_ready),
      .cmd_addr      (nice_icb_cmd_addr),
      .cmd_read      (nice_icb_cmd_read),
      .cmd_wdata     (nice_icb_cmd_wdata),
      .icb_rsp_valid (nice_icb_rsp_valid),
      .icb_rsp_rdata (nice_icb_rsp_rdata),
      .icb_rsp_err   (nice_icb_rsp_err),
      .mem_holdup    (nice_mem_holdup),
      .beat          (beat_bus.seq),
      .rd_idx        (rd_idx),
      .rd_data       (rd_data),
      .sum_done      (sum_done),
      .row_sum       (row_sum)
   );

   rowsum_accumulator u_accumulator (
      .nice_clk  (nice_clk),
      .reset     (reset),
      .beat      (beat_bus.acc),
      .buf_we    (buf_we),
      .buf_idx   (buf_idx),
      .buf_wdata (buf_wdata),
      .col_idx   (col_idx),
      .col_data  (col_data),
      .sum_done  (sum_done),
      .row_sum   (row_sum)
   );

   // write port owned by the accumulator, store reads by the sequencer
   row_buffer u_row_buffer (
      .nice_clk (nice_clk),
      .reset    (reset),
      .we       (buf_we),
      .wr_idx   (buf_idx),
      .wdata    (buf_wdata),
      .rd_idx   (rd_idx),
      .col_idx  (col_idx),
      .rd_data  (rd_data),
      .col_data (col_data)
   );

endmodule

// ==== hw/row_buffer.sv ====
// indices at or past the row length read as zero and are ignored on write
module row_buffer (
   input  logic               nice_clk,
   input  logic               reset,
   input  logic               we,
   input  nice_pkg::row_idx_t wr_idx,
   input  nice_pkg::xlen_t    wdata,
   input  nice_pkg::row_idx_t rd_idx,
   input  nice_pkg::row_idx_t col_idx,
   output nice_pkg::xlen_t    rd_data,
   output nice_pkg::xlen_t    col_data
);
   import nice_pkg::*;

   xlen_t rows [ROW_WORDS];

   // row starts out zero so a first rowsum adds onto a clean row
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         for (int i = 0; i < ROW_WORDS; i++) begin
            rows[i] <= '0;
         end
      end else if (we && (wr_idx < ROW_WORDS)) begin
         rows[wr_idx] <= wdata;
      end
   end

   // store read port
   assign rd_data  = (rd_idx < ROW_WORDS) ? rows[rd_idx] : '0;

   // column read for the accumulate
   assign col_data = (col_idx < ROW_WORDS) ? rows[col_idx] : '0;

endmodule

// ==== hw/rowsum_accumulator.sv ====
// every beat is registered before use; one row write per beat, sum_done follows the last column
module rowsum_accumulator (
   input  logic               nice_clk,
   input  logic               reset,
   nice_beat_if.acc           beat,
   output logic               buf_we,
   output nice_pkg::row_idx_t buf_idx,
   output nice_pkg::xlen_t    buf_wdata,
   output nice_pkg::row_idx_t col_idx,
   input  nice_pkg::xlen_t    col_data,
   output logic               sum_done,
   output nice_pkg::xlen_t    row_sum
);
   import nice_pkg::*;

   // receive buffer, so the adders start from registers
   logic       rcv_valid;
   beat_kind_e rcv_kind;
   row_idx_t   rcv_idx;
   xlen_t      rcv_data;

   logic       acc_fire;
   xlen_t      col_sum;

   always_ff @(posedge nice_clk) begin
      if (reset) begin
         rcv_valid <= 1'b0;
      end else begin
         rcv_valid <= beat.valid;
      end
   end

   always_ff @(posedge nice_clk) begin
      if (beat.valid) begin
         rcv_kind <= beat.kind;
         rcv_idx  <= beat.idx;
         rcv_data <= beat.data;
      end
   end

   assign acc_fire = rcv_valid && (rcv_kind == beat_acc);

   // column add, wraps at 32 bits
   assign col_idx = rcv_idx;
   assign col_sum = col_data + rcv_data;

   // loads pass straight through, accumulates write back the column sum
   assign buf_we    = rcv_valid;
   assign buf_idx   = rcv_idx;
   assign buf_wdata = acc_fire ? col_sum : rcv_data;

   // row sum restarts on column 0
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         sum_done <= 1'b0;
         row_sum  <= '0;
      end else begin
         sum_done <= acc_fire && (rcv_idx == row_idx_t'(ROW_WORDS - 1));
         if (acc_fire) begin
            row_sum <= (rcv_idx == '0) ? rcv_data : row_sum + rcv_data;
         end
      end
   end

endmodule

// ==== hw/nice_sequencer.sv ====
// memory responses must be in order and no earlier than the cycle after their command
module nice_sequencer (
   input  logic               nice_clk,
   input  logic               reset,
   input  nice_pkg::nice_op_e op,
   input  logic               req_valid,
   input  nice_pkg::addr_t    req_rs1,
   output logic               req_ready,
   output logic               rsp_valid,
   input  logic               rsp_ready,
   output nice_pkg::xlen_t    rsp_rdat,
   output logic               rsp_err,
   output logic               cmd_valid,
   input  logic               cmd_ready,
   output nice_pkg::addr_t    cmd_addr,
   output logic               cmd_read,
   output nice_pkg::xlen_t    cmd_wdata,
   input  logic               icb_rsp_valid,
   input  nice_pkg::xlen_t    icb_rsp_rdata,
   input  logic               icb_rsp_err,
   output logic               mem_holdup,
   nice_beat_if.seq           beat,
   output nice_pkg::row_idx_t rd_idx,
   input  nice_pkg::xlen_t    rd_data,
   input  logic               sum_done,
   input  nice_pkg::xlen_t    row_sum
);
   import nice_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_lbuf,
      st_sbuf,
      st_rowsum,
      st_respond
   } seq_state_e;

   seq_state_e state;
   seq_state_e state_nxt;

   // commands accepted and responses seen in this instruction
   row_idx_t cmd_cnt;
   row_idx_t rsp_cnt;
   // address of the next command after the first
   addr_t    addr_r;
   xlen_t    rdat_r;
   logic     err_r;

   logic is_mem_op;
   logic busy;
   logic req_hsk;
   logic cmd_hsk;
   logic mem_rsp;
   logic last_rsp;
   logic rsp_hsk;

   ////////////////////////////////////////////////////////////////////////////
   // handshakes
   ////////////////////////////////////////////////////////////////////////////

   assign is_mem_op = (op != op_none);
   assign busy      = (state == st_lbuf) || (state == st_sbuf) || (state == st_rowsum);

   // decoded ops wait for the memory port, the first command leaves with the accept
   assign req_ready = (state == st_idle) && (!is_mem_op || cmd_ready);
   assign req_hsk   = req_valid && req_ready;

   assign rsp_valid = (state == st_respond);
   assign rsp_hsk   = rsp_valid && rsp_ready;
   assign rsp_rdat  = rdat_r;
   // sticky over the instruction, stable while in respond
   assign rsp_err   = err_r;

   assign mem_holdup = (state != st_idle);

   ////////////////////////////////////////////////////////////////////////////
   // memory command port
   ////////////////////////////////////////////////////////////////////////////

   // several commands may be in flight, only the count limits issue
   assign cmd_valid = (state == st_idle) ? (req_valid && is_mem_op)
                                         : (busy && (cmd_cnt < ROW_WORDS));
   assign cmd_hsk   = cmd_valid && cmd_ready;
   assign cmd_addr  = (state == st_idle) ? req_rs1 : addr_r;
   assign cmd_read  = (state == st_idle) ? (op != op_sbuf) : (state != st_sbuf);

   // store data comes from the row word at the command count
   assign rd_idx    = cmd_cnt;
   assign cmd_wdata = cmd_read ? '0 : rd_data;

   // responses only count while an instruction is running
   assign mem_rsp  = busy && icb_rsp_valid;
   assign last_rsp = mem_rsp && (rsp_cnt == row_idx_t'(ROW_WORDS - 1));

   // read responses become beats for the accumulator, store acks do not
   assign beat.valid = mem_rsp && (state != st_sbuf);
   assign beat.kind  = (state == st_rowsum) ? beat_acc : beat_load;
   assign beat.idx   = rsp_cnt;
   assign beat.data  = icb_rsp_rdata;

   ////////////////////////////////////////////////////////////////////////////
   // FSM
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            // op_none is taken and dropped, no response
            if (req_hsk) begin
               case (op)
                  op_lbuf:   state_nxt = st_lbuf;
                  op_sbuf:   state_nxt = st_sbuf;
                  op_rowsum: state_nxt = st_rowsum;
                  default:   state_nxt = st_idle;
               endcase
            end
         end
         st_lbuf,
         st_sbuf: begin
            if (last_rsp) begin
               state_nxt = st_respond;
            end
         end
         st_rowsum: begin
            // wait for the last column to be added
            if (sum_done) begin
               state_nxt = st_respond;
            end
         end
         st_respond: begin
            if (rsp_hsk) begin
               state_nxt = st_idle;
            end
         end
         default: state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge nice_clk) begin
      if (reset) begin
         state   <= st_idle;
         cmd_cnt <= '0;
         rsp_cnt <= '0;
         err_r   <= 1'b0;
         rdat_r  <= '0;
      end else begin
         state <= state_nxt;
         if (req_hsk && is_mem_op) begin
            // first command already went out with the accept
            cmd_cnt <= row_idx_t'(1);
            rsp_cnt <= '0;
            err_r   <= 1'b0;
            rdat_r  <= '0;
         end else begin
            if (busy && cmd_hsk) begin
               cmd_cnt <= cmd_cnt + 1'b1;
            end
            if (mem_rsp) begin
               rsp_cnt <= rsp_cnt + 1'b1;
               if (icb_rsp_err) begin
                  err_r <= 1'b1;
               end
            end
            if ((state == st_rowsum) && sum_done) begin
               rdat_r <= row_sum;
            end
            // back to row 0 so the next sbuf stores the first word first
            if (rsp_hsk) begin
               cmd_cnt <= '0;
            end
         end
      end
   end

   // next word address, seeded from rs1 on the first command
   always_ff @(posedge nice_clk) begin
      if (cmd_hsk) begin
         addr_r <= cmd_addr + addr_t'(WORD_BYTES);
      end
   end

endmodule

// ==== hw/nice_decode.sv ====
// purely combinational; anything not an exact custom-3 lbuf/sbuf/rowsum match decodes to op_none
module nice_decode (
   input  logic               req_valid,
   input  nice_pkg::xlen_t    req_inst,
   output nice_pkg::nice_op_e op
);
   import nice_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   // R type field split
   assign opcode = req_inst[6:0];
   assign funct3 = req_inst[14:12];
   assign funct7 = req_inst[31:25];

   // rd, rs1 and rs2 fields are don't care here
   always_comb begin
      op = op_none;
      if (req_valid && (opcode == OPCODE_CUSTOM3)) begin
         if ((funct3 == FUNCT3_BUF) && (funct7 == FUNCT7_LBUF)) begin
            op = op_lbuf;
         end else if ((funct3 == FUNCT3_BUF) && (funct7 == FUNCT7_SBUF)) begin
            op = op_sbuf;
         end else if ((funct3 == FUNCT3_ROWSUM) && (funct7 == FUNCT7_ROWSUM)) begin
            op = op_rowsum;
         end
         // other custom-3 encodings fall through as op_none
      end
   end

endmodule

// ==== hw/nice_beat_if.sv ====
// memory read beats, one-cycle pulses with no back-pressure; the receiver must take every beat
interface nice_beat_if;
   import nice_pkg::*;

   // one beat per accepted read response
   logic       valid;
   // load into the row or add into it
   beat_kind_e kind;
   // target column
   row_idx_t   idx;
   // word returned by memory
   xlen_t      data;

   // sequencer side drives the beat
   modport seq (output valid, kind, idx, data);

   // accumulator side only listens
   modport acc (input valid, kind, idx, data);

endinterface

// ==== hw/nice_pkg.sv ====
// shared types and custom-3 encodings; the row length is fixed and every access is one word
package nice_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////////////////////

   // data word as seen by the core and the memory port
   typedef logic [31:0] xlen_t;

   // byte address on the memory command port
   typedef logic [31:0] addr_t;

   // row buffer index, wide enough to also count to the row length
   typedef logic [1:0] row_idx_t;

   // words per row
   localparam int unsigned ROW_WORDS = 3;

   // byte step between consecutive words
   localparam int unsigned WORD_BYTES = 4;

   ////////////////////////////////////////////////////////////////////////////
   // instruction encodings, R type on custom-3
   ////////////////////////////////////////////////////////////////////////////

   localparam logic [6:0] OPCODE_CUSTOM3 = 7'b1111011;

   // lbuf and sbuf differ only in funct7
   localparam logic [2:0] FUNCT3_BUF    = 3'b010;
   localparam logic [2:0] FUNCT3_ROWSUM = 3'b110;

   localparam logic [6:0] FUNCT7_LBUF   = 7'b0000001;
   localparam logic [6:0] FUNCT7_SBUF   = 7'b0000010;
   localparam logic [6:0] FUNCT7_ROWSUM = 7'b0000110;

   ////////////////////////////////////////////////////////////////////////////
   // enums
   ////////////////////////////////////////////////////////////////////////////

   // decoded operation, op_none also covers "no request"
   typedef enum logic [1:0] {
      op_none,
      op_lbuf,
      op_sbuf,
      op_rowsum
   } nice_op_e;

   // what the accumulator does with a response beat
   typedef enum logic {
      beat_load,
      beat_acc
   } beat_kind_e;

endpackage
